// ==== adc_i2c_defs.svh ====
// Shared constants for the ADC I2C target
// The address is a 7-bit I2C address; the register pointer is the first data byte of a write
// Sample width must stay between 9 and 16 bits to fit two read bytes per channel

`ifndef ADC_I2C_DEFS_SVH
`define ADC_I2C_DEFS_SVH

// ----------------------------------------------------------------------
// I2C side
// ----------------------------------------------------------------------

// 7-bit target address
`define ADC_I2C_ADDR 7'h50

// Width of the register pointer written after the address
`define ADC_REG_PTR_W 3

// Fixed identity byte, second byte of a read from pointer 0
`define ADC_CTRL_ID 8'hAF

// ----------------------------------------------------------------------
// ADC side
// ----------------------------------------------------------------------

// Logical channels published to the I2C map
`define ADC_NUM_CH 5

`define ADC_SAMPLE_W 12
`define ADC_CHAN_ID_W 5

`endif

// ==== adc_i2c_pkg.sv ====
// Types shared by the ADC I2C RTL and its testbench
// Widths come from the defs header; the CSR word is fixed at 32 bits

package adc_i2c_pkg;

`include "adc_i2c_defs.svh"

    // ADC response stream, one sample per valid cycle
    typedef struct packed {
        logic                      valid;
        logic [`ADC_CHAN_ID_W-1:0] channel;
        logic [`ADC_SAMPLE_W-1:0]  data;
        logic                      sop;
        logic                      eop;
    } adc_resp_t;

    // Sequencer control port, bit 0 of writedata is run
    typedef struct packed {
        logic        write;
        logic [31:0] writedata;
    } adc_csr_t;

    // Single-cycle bus strobes plus the sampled SDA level
    typedef struct packed {
        logic start;
        logic stop;
        logic scl_rise;
        logic scl_fall;
        logic sda;
    } i2c_event_t;

    // Published samples, index is the logical channel
    typedef logic [`ADC_NUM_CH-1:0][`ADC_SAMPLE_W-1:0] adc_sample_arr_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_ADDR,
        ST_ADDR_ACK,
        ST_PTR,
        ST_WR_DATA,
        ST_WR_ACK,
        ST_RD_DATA,
        ST_RD_ACK,
        ST_IGNORE
    } i2c_state_e;

endpackage

// ==== i2c_bus_monitor.sv ====
// Oversamples SCL and SDA in clk_core; every strobe lags the pins by 3 cycles
// clk_core must run well above the SCL rate so that no edge is missed

`timescale 1ns/1ns

module i2c_bus_monitor import adc_i2c_pkg::*; (
    input  logic       clk_core,
    input  logic       reset_n,
    input  logic       scl,
    input  logic       sda_in,
    output i2c_event_t bus_evt
);

    // ------------------------------------------------------------------
    // Two-stage synchronizers
    // ------------------------------------------------------------------
    logic [1:0] scl_sync;
    logic [1:0] sda_sync;

    // Previous synchronized values for edge detection
    logic       scl_last;
    logic       sda_last;

    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            // Idle bus is high on both lines
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
            scl_last <= 1'b1;
            sda_last <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[0], scl};
            sda_sync <= {sda_sync[0], sda_in};
            scl_last <= scl_sync[1];
            sda_last <= sda_sync[1];
        end
    end

    // ------------------------------------------------------------------
    // Registered event detect
    // ------------------------------------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            bus_evt <= '0;
        end else begin
            // SDA moving while SCL is high
            bus_evt.start    <= scl_sync[1] && sda_last && !sda_sync[1];
            bus_evt.stop     <= scl_sync[1] && !sda_last && sda_sync[1];
            bus_evt.scl_rise <= scl_sync[1] && !scl_last;
            bus_evt.scl_fall <= !scl_sync[1] && scl_last;
            // Same latency as the strobes
            bus_evt.sda      <= sda_sync[1];
        end
    end

endmodule

// ==== i2c_adc_target.sv ====
// I2C target at ADC_I2C_ADDR; a write sets the pointer, then register 0 holds the enable bit
// A read starts at byte index 2*pointer; no clock stretching, the controller sets the pace
// A controller NACK on a read byte parks the FSM until the next start or stop

`timescale 1ns/1ns
`include "adc_i2c_defs.svh"

module i2c_adc_target import adc_i2c_pkg::*; (
    input  logic            clk_core,
    input  logic            reset_n,
    input  i2c_event_t      bus_evt,
    input  adc_sample_arr_t samples,
    output logic            adc_enable,
    output logic            sda_pull_low
);

    localparam int IDX_W = `ADC_REG_PTR_W + 1;

    i2c_state_e                state;
    logic [7:0]                shift_reg;
    logic [7:0]                tx_reg;
    logic [3:0]                bit_cnt;
    logic                      rw_bit;
    logic                      wr_applied;
    logic [`ADC_REG_PTR_W-1:0] reg_ptr;
    logic [IDX_W-1:0]          byte_idx;
    logic [IDX_W-1:0]          ch_sel;
    logic [7:0]                rd_byte;
    logic                      byte_done;

    // Falling SCL after the eighth data bit
    assign byte_done = bus_evt.scl_fall && (bit_cnt == 4'd8);

    // ------------------------------------------------------------------
    // Read byte map
    // ------------------------------------------------------------------
    assign ch_sel = (byte_idx - IDX_W'(2)) >> 1;

    always_comb begin
        rd_byte = 8'h00;
        if (byte_idx == IDX_W'(0)) begin
            rd_byte = {6'b000000, 1'b1, adc_enable};
        end else if (byte_idx == IDX_W'(1)) begin
            rd_byte = `ADC_CTRL_ID;
        end else if (byte_idx < IDX_W'(2 * `ADC_NUM_CH + 2)) begin
            // Low byte on even index, zero-extended upper bits on odd
            if (!byte_idx[0]) begin
                rd_byte = samples[ch_sel][7:0];
            end else begin
                rd_byte = 8'(samples[ch_sel][`ADC_SAMPLE_W-1:8]);
            end
        end
    end

    // ------------------------------------------------------------------
    // Target FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            state        <= ST_IDLE;
            shift_reg    <= '0;
            tx_reg       <= '0;
            bit_cnt      <= '0;
            rw_bit       <= 1'b0;
            wr_applied   <= 1'b0;
            reg_ptr      <= '0;
            byte_idx     <= '0;
            adc_enable   <= 1'b0;
            sda_pull_low <= 1'b0;
        end else if (bus_evt.start) begin
            // Also covers a repeated start
            state        <= ST_ADDR;
            bit_cnt      <= '0;
            wr_applied   <= 1'b0;
            sda_pull_low <= 1'b0;
        end else if (bus_evt.stop) begin
            state        <= ST_IDLE;
            bit_cnt      <= '0;
            sda_pull_low <= 1'b0;
        end else begin
            // Bit counting on every data phase, shifting matters only when receiving
            if (bus_evt.scl_rise &&
                (state inside {ST_ADDR, ST_PTR, ST_WR_DATA, ST_RD_DATA})) begin
                shift_reg <= {shift_reg[6:0], bus_evt.sda};
                bit_cnt   <= bit_cnt + 4'd1;
            end

            case (state)
                ST_ADDR: begin
                    if (byte_done) begin
                        bit_cnt <= '0;
                        if (shift_reg[7:1] == `ADC_I2C_ADDR) begin
                            rw_bit       <= shift_reg[0];
                            byte_idx     <= {reg_ptr, 1'b0};
                            sda_pull_low <= 1'b1;
                            state        <= ST_ADDR_ACK;
                        end else begin
                            state <= ST_IGNORE;
                        end
                    end
                end
                ST_ADDR_ACK: begin
                    if (bus_evt.scl_fall) begin
                        if (rw_bit) begin
                            // First read bit goes out with the ack release
                            tx_reg       <= rd_byte;
                            sda_pull_low <= !rd_byte[7];
                            byte_idx     <= byte_idx + IDX_W'(1);
                            state        <= ST_RD_DATA;
                        end else begin
                            sda_pull_low <= 1'b0;
                            state        <= ST_PTR;
                        end
                    end
                end
                ST_PTR: begin
                    if (byte_done) begin
                        bit_cnt      <= '0;
                        reg_ptr      <= shift_reg[`ADC_REG_PTR_W-1:0];
                        sda_pull_low <= 1'b1;
                        state        <= ST_WR_ACK;
                    end
                end
                ST_WR_DATA: begin
                    if (byte_done) begin
                        bit_cnt <= '0;
                        // Only the byte right after the pointer counts
                        if (!wr_applied && (reg_ptr == '0)) begin
                            adc_enable <= shift_reg[0];
                        end
                        wr_applied   <= 1'b1;
                        sda_pull_low <= 1'b1;
                        state        <= ST_WR_ACK;
                    end
                end
                ST_WR_ACK: begin
                    if (bus_evt.scl_fall) begin
                        sda_pull_low <= 1'b0;
                        state        <= ST_WR_DATA;
                    end
                end
                ST_RD_DATA: begin
                    if (byte_done) begin
                        bit_cnt      <= '0;
                        sda_pull_low <= 1'b0;
                        state        <= ST_RD_ACK;
                    end else if (bus_evt.scl_fall) begin
                        tx_reg       <= {tx_reg[6:0], 1'b0};
                        sda_pull_low <= !tx_reg[6];
                    end
                end
                ST_RD_ACK: begin
                    if (bus_evt.scl_rise && bus_evt.sda) begin
                        // NACK from the controller ends the read
                        state <= ST_IGNORE;
                    end else if (bus_evt.scl_fall) begin
                        tx_reg       <= rd_byte;
                        sda_pull_low <= !rd_byte[7];
                        if (byte_idx != '1) begin
                            byte_idx <= byte_idx + IDX_W'(1);
                        end
                        state <= ST_RD_DATA;
                    end
                end
                default: begin
                    // Idle and ignore wait for a start or stop
                end
            endcase
        end
    end

endmodule

// ==== adc_sample_bank.sv ====
// Captures converter channels 1, 2, 3, 4 and 6 as logical channels 0 to 4
// Samples are published only on a valid response with end-of-packet set
// Each enable change issues one sequencer write; a stop write follows reset

`timescale 1ns/1ns
`include "adc_i2c_defs.svh"

module adc_sample_bank import adc_i2c_pkg::*; (
    input  logic            clk_core,
    input  logic            reset_n,
    input  adc_resp_t       adc_resp,
    input  logic            adc_enable,
    output adc_sample_arr_t samples,
    output adc_csr_t        adc_csr
);

    localparam int IDX_W = $clog2(`ADC_NUM_CH);

    adc_sample_arr_t  raw;
    logic             ch_hit;
    logic [IDX_W-1:0] ch_idx;
    logic             last_enable;
    logic             boot_pending;

    // Converter id to logical channel
    always_comb begin
        ch_hit = 1'b1;
        ch_idx = '0;
        case (adc_resp.channel)
            `ADC_CHAN_ID_W'(1): ch_idx = IDX_W'(0);
            `ADC_CHAN_ID_W'(2): ch_idx = IDX_W'(1);
            `ADC_CHAN_ID_W'(3): ch_idx = IDX_W'(2);
            `ADC_CHAN_ID_W'(4): ch_idx = IDX_W'(3);
            `ADC_CHAN_ID_W'(6): ch_idx = IDX_W'(4);
            default: ch_hit = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // Raw capture and publish
    // ------------------------------------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            raw     <= '0;
            samples <= '0;
        end else if (adc_resp.valid) begin
            if (ch_hit) begin
                raw[ch_idx] <= adc_resp.data;
            end
            // Old raw values go out, a sample in this same beat lands next packet
            if (adc_resp.eop) begin
                samples <= raw;
            end
        end
    end

    // ------------------------------------------------------------------
    // Sequencer run/stop command
    // ------------------------------------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            adc_csr      <= '0;
            last_enable  <= 1'b0;
            boot_pending <= 1'b1;
        end else begin
            adc_csr.write     <= boot_pending || (adc_enable != last_enable);
            adc_csr.writedata <= {31'b0, adc_enable};
            last_enable       <= adc_enable;
            boot_pending      <= 1'b0;
        end
    end

endmodule

// ==== adc_i2c_top.sv ====
// ADC access path of the board controller, one clock domain on clk_core
// SDA is open drain; the pull-up is external to this block

`timescale 1ns/1ns

module adc_i2c_top import adc_i2c_pkg::*; (
    input  logic      clk_core,
    input  logic      reset_n,
    input  logic      scl,
    inout  wire       sda,
    input  adc_resp_t adc_resp,
    output adc_csr_t  adc_csr
);

    i2c_event_t      bus_evt;
    adc_sample_arr_t samples;
    logic            adc_enable;
    logic            sda_pull_low;

    // Open-drain driver, release means high through the pull-up
    assign sda = sda_pull_low ? 1'b0 : 1'bz;

    i2c_bus_monitor u_bus_monitor (
        .clk_core (clk_core),
        .reset_n  (reset_n),
        .scl      (scl),
        .sda_in   (sda),
        .bus_evt  (bus_evt)
    );

    i2c_adc_target u_target (
        .clk_core     (clk_core),
        .reset_n      (reset_n),
        .bus_evt      (bus_evt),
        .samples      (samples),
        .adc_enable   (adc_enable),
        .sda_pull_low (sda_pull_low)
    );

    adc_sample_bank u_sample_bank (
        .clk_core   (clk_core),
        .reset_n    (reset_n),
        .adc_resp   (adc_resp),
        .adc_enable (adc_enable),
        .samples    (samples),
        .adc_csr    (adc_csr)
    );

endmodule

// ==== adc_i2c_properties.sv ====
// Concurrent checks on the sequencer command port and the target SDA driver
// Bound into the sample bank and the target; each host ties off what it does not own

`timescale 1ns/1ns

module adc_i2c_properties import adc_i2c_pkg::*; (
    input logic       clk_core,
    input logic       reset_n,
    input adc_csr_t   adc_csr,
    input i2c_state_e state,
    input logic       sda_pull_low
);

    // Command writes are single-cycle pulses
    csr_single_pulse: assert property (@(posedge clk_core) disable iff (!reset_n)
        adc_csr.write |=> !adc_csr.write)
        else $error("adc_csr write high on two consecutive cycles");

    csr_run_bit_only: assert property (@(posedge clk_core) disable iff (!reset_n)
        adc_csr.write |-> (adc_csr.writedata[31:1] == '0))
        else $error("adc_csr writedata 0x%08h has bits above bit 0", adc_csr.writedata);

    // Idle and ignore never hold the line
    sda_quiet: assert property (@(posedge clk_core) disable iff (!reset_n)
        (state inside {ST_IDLE, ST_IGNORE}) |-> !sda_pull_low)
        else $error("sda_pull_low active in state %s", state.name());

endmodule

bind adc_sample_bank adc_i2c_properties u_csr_props (
    .clk_core     (clk_core),
    .reset_n      (reset_n),
    .adc_csr      (adc_csr),
    .state        (adc_i2c_pkg::ST_IDLE),
    .sda_pull_low (1'b0)
);

bind i2c_adc_target adc_i2c_properties u_sda_props (
    .clk_core     (clk_core),
    .reset_n      (reset_n),
    .adc_csr      (adc_i2c_pkg::adc_csr_t'('0)),
    .state        (state),
    .sda_pull_low (sda_pull_low)
);

// ==== tb_adc_i2c.sv ====
// Testbench for adc_i2c_top with a bit-banged I2C controller and an ADC response driver
// One SCL bit takes 24 clk_core cycles; the sda pull-up lives here

`timescale 1ns/1ns
`include "adc_i2c_defs.svh"

module tb_adc_i2c import adc_i2c_pkg::*; ();

    localparam int HALF     = 12;
    localparam int CSR_WAIT = 40;

    logic      clk_core;
    logic      reset_n;
    logic      scl;
    logic      sda_low;
    wire       sda;
    adc_resp_t adc_resp;
    adc_csr_t  adc_csr;

    int          errors;
    int          checks;
    integer      seed;
    logic [31:0] csr_q[$];
    logic [7:0]  got_q[$];
    logic [7:0]  exp_q[$];
    int          idx_q[$];
    event        byte_read;

    // Model of the enable bit and of the raw and published samples
    bit                       model_enable;
    logic [`ADC_SAMPLE_W-1:0] model_raw [`ADC_NUM_CH];
    logic [`ADC_SAMPLE_W-1:0] model_pub [`ADC_NUM_CH];

    pullup (sda);
    assign sda = sda_low ? 1'b0 : 1'bz;

    adc_i2c_top dut (
        .clk_core (clk_core),
        .reset_n  (reset_n),
        .scl      (scl),
        .sda      (sda),
        .adc_resp (adc_resp),
        .adc_csr  (adc_csr)
    );

    initial begin
        clk_core = 1'b0;
        forever #10 clk_core = ~clk_core;
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic logic [7:0] expected_byte(input int idx, input bit en,
            input logic [`ADC_SAMPLE_W-1:0] pub [`ADC_NUM_CH]);
        int k;
        k = (idx - 2) / 2;
        if (idx == 0) begin
            return {7'h01, en};
        end else if (idx == 1) begin
            return `ADC_CTRL_ID;
        end else if (idx < 2 * `ADC_NUM_CH + 2) begin
            return (idx % 2 == 0) ? pub[k][7:0] : {4'h0, pub[k][11:8]};
        end
        return 8'h00;
    endfunction

    // Converter id to logical channel or -1 when not captured
    function automatic int logical_channel(input int id);
        case (id)
            1, 2, 3, 4: return id - 1;
            6: return 4;
            default: return -1;
        endcase
    endfunction

    // All driving and sampling happens 2 ns after a rising edge
    task automatic tick(input int n);
        repeat (n) @(posedge clk_core);
        #2;
    endtask

    // ------------------------------------------------------------------
    // I2C controller
    // ------------------------------------------------------------------
    task automatic i2c_start();
        sda_low = 1'b1;
        tick(HALF);
        scl = 1'b0;
        tick(HALF);
    endtask

    task automatic i2c_stop();
        tick(4);
        sda_low = 1'b1;
        tick(HALF - 4);
        scl = 1'b1;
        tick(HALF);
        sda_low = 1'b0;
        tick(HALF);
    endtask

    // Data moves a few cycles into the low phase
    task automatic drive_bit(input bit b);
        tick(4);
        sda_low = !b;
        tick(HALF - 4);
        scl = 1'b1;
        tick(HALF);
        scl = 1'b0;
    endtask

    task automatic write_byte(input logic [7:0] b, output bit ack);
        int n;
        for (int i = 7; i >= 0; i--) begin
            drive_bit(b[i]);
        end
        tick(4);
        sda_low = 1'b0;
        tick(HALF - 4);
        scl = 1'b1;
        ack = 1'b0;
        n = 0;
        while (!ack && n < HALF) begin
            tick(1);
            n++;
            ack = (sda === 1'b0);
        end
        if (n < HALF) begin
            tick(HALF - n);
        end
        scl = 1'b0;
    endtask

    task automatic send_acked(input logic [7:0] b);
        bit ack;
        write_byte(b, ack);
        checks++;
        assert (ack) else begin
            errors++;
            $display("Target did not acknowledge byte 0x%02h within %0d cycles", b, HALF);
        end
    endtask

    task automatic read_byte(input bit ack, output logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            tick(4);
            sda_low = 1'b0;
            tick(HALF - 4);
            scl = 1'b1;
            tick(HALF / 2);
            b[i] = sda;
            tick(HALF / 2);
            scl = 1'b0;
        end
        drive_bit(!ack);
    endtask

    // After a NACK the target must leave SDA alone
    task automatic check_released();
        int n;
        n = 0;
        while (n < HALF && sda === 1'b1) begin
            tick(1);
            n++;
        end
        checks++;
        assert (n == HALF) else begin
            errors++;
            $display("Target pulled SDA low after the controller NACK");
        end
    endtask

    task automatic set_pointer(input logic [7:0] ptr);
        i2c_start();
        send_acked({`ADC_I2C_ADDR, 1'b0});
        send_acked(ptr);
        i2c_stop();
    endtask

    task automatic write_enable(input bit en);
        i2c_start();
        send_acked({`ADC_I2C_ADDR, 1'b0});
        send_acked(8'h00);
        send_acked({7'h00, en});
        i2c_stop();
        model_enable = en;
    endtask

    task automatic read_and_check(input int ptr, input int count);
        logic [7:0] b;
        set_pointer(8'(ptr));
        i2c_start();
        send_acked({`ADC_I2C_ADDR, 1'b1});
        for (int i = 0; i < count; i++) begin
            read_byte(i != count - 1, b);
            got_q.push_back(b);
            exp_q.push_back(expected_byte(2 * ptr + i, model_enable, model_pub));
            idx_q.push_back(2 * ptr + i);
            -> byte_read;
        end
        check_released();
        i2c_stop();
    endtask

    // ------------------------------------------------------------------
    // ADC response stream and sequencer commands
    // ------------------------------------------------------------------
    task automatic send_resp(input int id, input logic [11:0] data, input bit sop,
            input bit eop);
        int ch;
        adc_resp.valid   = 1'b1;
        adc_resp.channel = id[`ADC_CHAN_ID_W-1:0];
        adc_resp.data    = data;
        adc_resp.sop     = sop;
        adc_resp.eop     = eop;
        tick(1);
        adc_resp = '0;
        // Publish takes the raw values from before this beat
        if (eop) begin
            model_pub = model_raw;
        end
        ch = logical_channel(id);
        if (ch >= 0) begin
            model_raw[ch] = data;
        end
    endtask

    task automatic send_packet(input bit with_eop);
        int ids [5];
        ids = '{1, 2, 3, 4, 6};
        for (int i = 0; i < 5; i++) begin
            send_resp(ids[i], 12'($random(seed)), i == 0, with_eop && i == 4);
        end
    endtask

    always @(negedge clk_core) begin
        if (reset_n && adc_csr.write) begin
            csr_q.push_back(adc_csr.writedata);
        end
    end

    task automatic expect_csr(input logic [31:0] value);
        int n;
        logic [31:0] got;
        n = 0;
        while (csr_q.size() == 0 && n < CSR_WAIT) begin
            tick(1);
            n++;
        end
        checks++;
        assert (csr_q.size() == 1) else begin
            errors++;
            $display("Expected one sequencer command write, saw %0d", csr_q.size());
        end
        if (csr_q.size() != 0) begin
            got = csr_q.pop_front();
            checks++;
            assert (got == value) else begin
                errors++;
                $display("ERR adc_csr.writedata got 0x%08h expected 0x%08h", got, value);
            end
        end
        csr_q.delete();
    endtask

    task automatic check_no_csr();
        checks++;
        assert (csr_q.size() == 0) else begin
            errors++;
            $display("Unexpected sequencer command write, %0d seen", csr_q.size());
        end
        csr_q.delete();
    endtask

    // ------------------------------------------------------------------
    // Read byte compare
    // ------------------------------------------------------------------
    initial begin
        logic [7:0] got;
        logic [7:0] exp;
        int         idx;
        forever begin
            @(byte_read);
            while (got_q.size() != 0) begin
                got = got_q.pop_front();
                exp = exp_q.pop_front();
                idx = idx_q.pop_front();
                checks++;
                assert (got == exp) else begin
                    errors++;
                    $display("ERR rd_byte[%0d] got 0x%02h expected 0x%02h", idx, got, exp);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        bit ack;
        errors       = 0;
        checks       = 0;
        seed         = 32'h0de53209;
        scl          = 1'b1;
        sda_low      = 1'b0;
        adc_resp     = '0;
        reset_n      = 1'b0;
        model_enable = 1'b0;
        model_raw    = '{default: '0};
        model_pub    = '{default: '0};
        repeat (3) @(posedge clk_core);
        #2 reset_n = 1'b1;

        // Stop command after reset and then the empty map
        expect_csr(32'h0);
        read_and_check(0, 12);
        check_no_csr();

        // Run and stop through register 0
        write_enable(1'b1);
        expect_csr(32'h1);
        read_and_check(0, 2);
        write_enable(1'b0);
        expect_csr(32'h0);

        // Two full packets and then samples from pointer 1
        send_packet(1'b1);
        send_packet(1'b1);
        read_and_check(1, 10);

        // No end-of-packet
        send_packet(1'b0);
        read_and_check(1, 10);

        // Ignored ids ahead of the closing beat
        send_resp(0, 12'($random(seed)), 1'b1, 1'b0);
        send_resp(5, 12'($random(seed)), 1'b0, 1'b0);
        send_resp(7, 12'($random(seed)), 1'b0, 1'b0);
        send_resp(0, 12'($random(seed)), 1'b0, 1'b1);
        read_and_check(1, 10);

        // Foreign address is not acknowledged
        i2c_start();
        write_byte({7'h51, 1'b0}, ack);
        checks++;
        assert (!ack) else begin
            errors++;
            $display("Target acknowledged address 0x51");
        end
        i2c_stop();
        read_and_check(0, 4);

        // Pointers past the sample map
        read_and_check(6, 3);
        read_and_check(7, 3);
        check_no_csr();

        tick(4);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (400000) @(posedge clk_core);
        $display("Simulation did not finish within 400000 clock cycles");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== adc_i2c.f ====
+incdir+.
adc_i2c_pkg.sv
i2c_bus_monitor.sv
i2c_adc_target.sv
adc_sample_bank.sv
adc_i2c_top.sv
adc_i2c_properties.sv
tb_adc_i2c.sv
